/* design/krv_periph_pkg.sv */
`default_nettype none

package krv_periph_pkg;

	// Bus and pin widths
	localparam int AHB_ADDR_WIDTH = 32;
	localparam int AHB_DATA_WIDTH = 32;
	localparam int GPIO_WIDTH     = 8;
	// Claim holds index plus one, zero means nothing pending
	localparam int CLAIM_WIDTH    = $clog2(GPIO_WIDTH + 1);

	// Transfer codes in use
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Slave region field of haddr
	localparam int REGION_MSB = 15;
	localparam int REGION_LSB = 12;

	localparam logic [3:0] REGION_GPIO  = 4'd0;
	localparam logic [3:0] REGION_KPLIC = 4'd1;
	localparam logic [3:0] REGION_TIMER = 4'd2;

	// Word offset field of haddr
	localparam int OFS_MSB = 3;
	localparam int OFS_LSB = 2;

	localparam logic [1:0] GPIO_OUT_OFS = 2'd0;
	localparam logic [1:0] GPIO_IN_OFS  = 2'd1;

	localparam logic [1:0] KPLIC_ENABLE_OFS  = 2'd0;
	localparam logic [1:0] KPLIC_PENDING_OFS = 2'd1;
	localparam logic [1:0] KPLIC_CLAIM_OFS   = 2'd2;

	localparam logic [1:0] MTIME_LO_OFS    = 2'd0;
	localparam logic [1:0] MTIME_HI_OFS    = 2'd1;
	localparam logic [1:0] MTIMECMP_LO_OFS = 2'd2;
	localparam logic [1:0] MTIMECMP_HI_OFS = 2'd3;

	localparam logic [63:0] MTIMECMP_RESET = '1;

	// Machine time, counted as one word, accessed by halves
	// half[1] is the high word, half[0] the low word
	typedef union packed {
		logic [63:0]                    full;
		logic [1:0][AHB_DATA_WIDTH-1:0] half;
	} mtime_u;

endpackage

`default_nettype wire

/* design/rst_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_sync (
	input  logic hclk,
	input  logic arst_n,
	output logic hresetn
);

	logic [1:0] sync_q;

	// Assert at once, release after two edges
	always_ff @(posedge hclk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign hresetn = sync_q[1];

endmodule

`default_nettype wire

/* design/ahb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_decoder (
	input  logic                                     hclk,
	input  logic                                     hresetn,
	input  logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr,
	input  logic [1:0]                               htrans,
	output logic                                     gpio_sel,
	output logic                                     kplic_sel,
	output logic                                     timer_sel,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] gpio_rdata,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] kplic_rdata,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] timer_rdata,
	output logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hrdata,
	output logic                                     hready,
	output logic                                     hresp
);

	logic       addr_phase;
	logic [3:0] region;
	logic       unmapped;

	// Data phase owner flags
	logic dp_gpio;
	logic dp_kplic;
	logic dp_timer;

	// First and second cycle of the error response
	logic err_first;
	logic err_second;

	assign addr_phase = (htrans == krv_periph_pkg::HTRANS_NONSEQ) && hready;
	assign region     = haddr[krv_periph_pkg::REGION_MSB:krv_periph_pkg::REGION_LSB];

	assign gpio_sel  = addr_phase && (region == krv_periph_pkg::REGION_GPIO);
	assign kplic_sel = addr_phase && (region == krv_periph_pkg::REGION_KPLIC);
	assign timer_sel = addr_phase && (region == krv_periph_pkg::REGION_TIMER);
	assign unmapped  = addr_phase && !(gpio_sel || kplic_sel || timer_sel);

	// Selects already carry hready, so load every cycle
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			dp_gpio    <= 1'b0;
			dp_kplic   <= 1'b0;
			dp_timer   <= 1'b0;
			err_first  <= 1'b0;
			err_second <= 1'b0;
		end else begin
			dp_gpio    <= gpio_sel;
			dp_kplic   <= kplic_sel;
			dp_timer   <= timer_sel;
			err_first  <= unmapped;
			err_second <= err_first;
		end
	end

	// Read mux, zero for an error or an idle data phase
	always_comb begin
		hrdata = '0;
		if (dp_gpio) begin
			hrdata = gpio_rdata;
		end else if (dp_kplic) begin
			hrdata = kplic_rdata;
		end else if (dp_timer) begin
			hrdata = timer_rdata;
		end
	end

	assign hready = !err_first;
	assign hresp  = err_first || err_second;

	// Two-cycle error response
	a_err_two_cycle: assert property (
		@(posedge hclk) disable iff (!hresetn)
		(hresp && !hready) |=> (hresp && hready)
	);

endmodule

`default_nettype wire

/* design/gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio (
	input  logic                                     hclk,
	input  logic                                     hresetn,
	input  logic                                     gpio_sel,
	input  logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr,
	input  logic                                     hwrite,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hwdata,
	output logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] gpio_rdata,
	input  logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_in,
	output logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_out,
	output logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_sync
);

	localparam int PAD = krv_periph_pkg::AHB_DATA_WIDTH - krv_periph_pkg::GPIO_WIDTH;

	logic                                  dp_sel;
	logic                                  dp_write;
	logic [1:0]                            dp_ofs;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0] in_meta;

	always_ff @(posedge hclk) begin
		if (gpio_sel) begin
			dp_write <= hwrite;
			dp_ofs   <= haddr[krv_periph_pkg::OFS_MSB:krv_periph_pkg::OFS_LSB];
		end
	end

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			dp_sel    <= 1'b0;
			gpio_out  <= '0;
			in_meta   <= '0;
			gpio_sync <= '0;
		end else begin
			dp_sel    <= gpio_sel;
			// Pins are asynchronous to hclk
			in_meta   <= gpio_in;
			gpio_sync <= in_meta;
			if (dp_sel && dp_write && (dp_ofs == krv_periph_pkg::GPIO_OUT_OFS)) begin
				gpio_out <= hwdata[krv_periph_pkg::GPIO_WIDTH-1:0];
			end
		end
	end

	always_comb begin
		case (dp_ofs)
			krv_periph_pkg::GPIO_OUT_OFS: gpio_rdata = {{PAD{1'b0}}, gpio_out};
			krv_periph_pkg::GPIO_IN_OFS:  gpio_rdata = {{PAD{1'b0}}, gpio_sync};
			default:                      gpio_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/kplic.sv */
`timescale 1ns/1ps
`default_nettype none

module kplic (
	input  logic                                     hclk,
	input  logic                                     hresetn,
	input  logic                                     kplic_sel,
	input  logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr,
	input  logic                                     hwrite,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hwdata,
	input  logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_sync,
	output logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] kplic_rdata,
	output logic                                     kplic_int
);

	localparam int SRC_PAD   = krv_periph_pkg::AHB_DATA_WIDTH - krv_periph_pkg::GPIO_WIDTH;
	localparam int CLAIM_PAD = krv_periph_pkg::AHB_DATA_WIDTH - krv_periph_pkg::CLAIM_WIDTH;

	logic                                   dp_sel;
	logic                                   dp_write;
	logic [1:0]                             dp_ofs;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0]  enable;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0]  pending;
	logic [krv_periph_pkg::CLAIM_WIDTH-1:0] claim;

	always_ff @(posedge hclk) begin
		if (kplic_sel) begin
			dp_write <= hwrite;
			dp_ofs   <= haddr[krv_periph_pkg::OFS_MSB:krv_periph_pkg::OFS_LSB];
		end
	end

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			dp_sel <= 1'b0;
			enable <= '0;
		end else begin
			dp_sel <= kplic_sel;
			if (dp_sel && dp_write && (dp_ofs == krv_periph_pkg::KPLIC_ENABLE_OFS)) begin
				enable <= hwdata[krv_periph_pkg::GPIO_WIDTH-1:0];
			end
		end
	end

	// Level sources, no latching
	assign pending   = enable & gpio_sync;
	assign kplic_int = |pending;

	// Scan from the top so the lowest pending source wins
	always_comb begin
		claim = '0;
		for (int i = krv_periph_pkg::GPIO_WIDTH - 1; i >= 0; i--) begin
			if (pending[i]) begin
				claim = krv_periph_pkg::CLAIM_WIDTH'(i + 1);
			end
		end
	end

	always_comb begin
		case (dp_ofs)
			krv_periph_pkg::KPLIC_ENABLE_OFS:  kplic_rdata = {{SRC_PAD{1'b0}}, enable};
			krv_periph_pkg::KPLIC_PENDING_OFS: kplic_rdata = {{SRC_PAD{1'b0}}, pending};
			krv_periph_pkg::KPLIC_CLAIM_OFS:   kplic_rdata = {{CLAIM_PAD{1'b0}}, claim};
			default:                           kplic_rdata = '0;
		endcase
	end

	a_int_has_claim: assert property (
		@(posedge hclk) disable iff (!hresetn)
		kplic_int |-> (claim != '0)
	);

endmodule

`default_nettype wire

/* design/core_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module core_timer (
	input  logic                                     hclk,
	input  logic                                     hresetn,
	input  logic                                     timer_sel,
	input  logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr,
	input  logic                                     hwrite,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hwdata,
	output logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] timer_rdata,
	output logic                                     core_timer_int
);

	logic                  dp_sel;
	logic                  dp_write;
	logic [1:0]            dp_ofs;
	logic                  wr_en;
	krv_periph_pkg::mtime_u mtime;
	krv_periph_pkg::mtime_u mtimecmp;

	always_ff @(posedge hclk) begin
		if (timer_sel) begin
			dp_write <= hwrite;
			dp_ofs   <= haddr[krv_periph_pkg::OFS_MSB:krv_periph_pkg::OFS_LSB];
		end
	end

	assign wr_en = dp_sel && dp_write;

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			dp_sel <= 1'b0;
		end else begin
			dp_sel <= timer_sel;
		end
	end

	// Free-running count, a half write takes the place of the increment
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			mtime.full <= '0;
		end else if (wr_en && (dp_ofs == krv_periph_pkg::MTIME_LO_OFS)) begin
			mtime.half[0] <= hwdata;
		end else if (wr_en && (dp_ofs == krv_periph_pkg::MTIME_HI_OFS)) begin
			mtime.half[1] <= hwdata;
		end else begin
			mtime.full <= mtime.full + 64'd1;
		end
	end

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			mtimecmp.full <= krv_periph_pkg::MTIMECMP_RESET;
		end else if (wr_en && (dp_ofs == krv_periph_pkg::MTIMECMP_LO_OFS)) begin
			mtimecmp.half[0] <= hwdata;
		end else if (wr_en && (dp_ofs == krv_periph_pkg::MTIMECMP_HI_OFS)) begin
			mtimecmp.half[1] <= hwdata;
		end
	end

	// One cycle behind the compare
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			core_timer_int <= 1'b0;
		end else begin
			core_timer_int <= (mtime.full >= mtimecmp.full);
		end
	end

	always_comb begin
		case (dp_ofs)
			krv_periph_pkg::MTIME_LO_OFS:    timer_rdata = mtime.half[0];
			krv_periph_pkg::MTIME_HI_OFS:    timer_rdata = mtime.half[1];
			krv_periph_pkg::MTIMECMP_LO_OFS: timer_rdata = mtimecmp.half[0];
			default:                         timer_rdata = mtimecmp.half[1];
		endcase
	end

	// Compare starts at all ones, so no interrupt right after reset
	a_no_int_after_reset: assert property (
		@(posedge hclk)
		$rose(hresetn) |-> !core_timer_int [*2]
	);

endmodule

`default_nettype wire

/* design/krv_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module krv_periph (
	input  logic                                     hclk,
	input  logic                                     arst_n,
	input  logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr,
	input  logic [1:0]                               htrans,
	input  logic                                     hwrite,
	input  logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hwdata,
	output logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hrdata,
	output logic                                     hready,
	output logic                                     hresp,
	input  logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_in,
	output logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_out,
	output logic                                     core_timer_int,
	output logic                                     kplic_int
);

	logic                                     hresetn;
	logic                                     gpio_sel;
	logic                                     kplic_sel;
	logic                                     timer_sel;
	logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] gpio_rdata;
	logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] kplic_rdata;
	logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] timer_rdata;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_sync;

	rst_sync u_rst_sync (
		.hclk    (hclk),
		.arst_n  (arst_n),
		.hresetn (hresetn)
	);

	ahb_decoder u_ahb_decoder (
		.hclk        (hclk),
		.hresetn     (hresetn),
		.haddr       (haddr),
		.htrans      (htrans),
		.gpio_sel    (gpio_sel),
		.kplic_sel   (kplic_sel),
		.timer_sel   (timer_sel),
		.gpio_rdata  (gpio_rdata),
		.kplic_rdata (kplic_rdata),
		.timer_rdata (timer_rdata),
		.hrdata      (hrdata),
		.hready      (hready),
		.hresp       (hresp)
	);

	gpio u_gpio (
		.hclk       (hclk),
		.hresetn    (hresetn),
		.gpio_sel   (gpio_sel),
		.haddr      (haddr),
		.hwrite     (hwrite),
		.hwdata     (hwdata),
		.gpio_rdata (gpio_rdata),
		.gpio_in    (gpio_in),
		.gpio_out   (gpio_out),
		.gpio_sync  (gpio_sync)
	);

	// Interrupt sources are the synchronized GPIO inputs
	kplic u_kplic (
		.hclk        (hclk),
		.hresetn     (hresetn),
		.kplic_sel   (kplic_sel),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.hwdata      (hwdata),
		.gpio_sync   (gpio_sync),
		.kplic_rdata (kplic_rdata),
		.kplic_int   (kplic_int)
	);

	core_timer u_core_timer (
		.hclk           (hclk),
		.hresetn        (hresetn),
		.timer_sel      (timer_sel),
		.haddr          (haddr),
		.hwrite         (hwrite),
		.hwdata         (hwdata),
		.timer_rdata    (timer_rdata),
		.core_timer_int (core_timer_int)
	);

endmodule

`default_nettype wire

/* tb/krv_periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module krv_periph_tb;

	localparam int TIMEOUT = 200;

	logic                                     hclk;
	logic                                     arst_n;
	logic [krv_periph_pkg::AHB_ADDR_WIDTH-1:0] haddr;
	logic [1:0]                               htrans;
	logic                                     hwrite;
	logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hwdata;
	logic [krv_periph_pkg::AHB_DATA_WIDTH-1:0] hrdata;
	logic                                     hready;
	logic                                     hresp;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_in;
	logic [krv_periph_pkg::GPIO_WIDTH-1:0]     gpio_out;
	logic                                     core_timer_int;
	logic                                     kplic_int;

	logic [31:0] lfsr_state;
	int          n_checks;
	int          n_value_err;
	int          n_other_err;

	// Register model
	logic [7:0]  m_gpio_out;
	logic [7:0]  m_enable;
	logic [63:0] m_cmp;

	krv_periph dut_i (.*);

	initial begin
		hclk = 1'b0;
		forever #4 hclk = ~hclk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Bits 11 to 4 are not decoded, so they get random filler
	function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [1:0] ofs);
		logic [7:0] filler;
		filler = 8'(rand_bits(8));
		return {16'h0000, region, filler, ofs, 2'b00};
	endfunction

	// Lowest pending source wins and claims count from one
	function automatic logic [31:0] expected_claim(input logic [7:0] pend);
		for (int i = 0; i < 8; i++) begin
			if (pend[i]) begin
				return i + 1;
			end
		end
		return 0;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		assert (got === exp) else begin
			$display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
			n_value_err++;
		end
	endtask

	// Returns at a falling edge with hready high
	task automatic wait_ready(output int waits);
		waits = 0;
		@(negedge hclk);
		while (!hready && waits < TIMEOUT) begin
			@(negedge hclk);
			waits++;
		end
		assert (waits < TIMEOUT) else begin
			$display("Timeout at %0t: hready stayed low", $time);
			n_other_err++;
		end
	endtask

	// resp holds hresp of the first and the last data phase cycle
	task automatic transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output int waits, output logic [1:0] resp);
		int addr_waits;
		haddr  = addr;
		hwrite = wr;
		htrans = krv_periph_pkg::HTRANS_NONSEQ;
		wait_ready(addr_waits);
		check("addr waits", addr_waits, 0);
		@(posedge hclk);
		#1;
		htrans = krv_periph_pkg::HTRANS_IDLE;
		hwdata = wdata;
		@(negedge hclk);
		resp[1] = hresp;
		waits   = 0;
		while (!hready && waits < TIMEOUT) begin
			@(negedge hclk);
			waits++;
		end
		assert (waits < TIMEOUT) else begin
			$display("Timeout at %0t: data phase never completed", $time);
			n_other_err++;
		end
		rdata   = hrdata;
		resp[0] = hresp;
		@(posedge hclk);
		#1;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] rd;
		int          waits;
		logic [1:0]  resp;
		transfer(1'b1, addr, wdata, rd, waits, resp);
		check("write waits", waits, 0);
		check("write hresp", resp, 2'b00);
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata);
		int         waits;
		logic [1:0] resp;
		transfer(1'b0, addr, 32'h0, rdata, waits, resp);
		check("read waits", waits, 0);
		check("read hresp", resp, 2'b00);
	endtask

	// Read address phase overlaps the write data phase
	task automatic write_read(input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waits;
		haddr  = addr;
		hwrite = 1'b1;
		htrans = krv_periph_pkg::HTRANS_NONSEQ;
		wait_ready(waits);
		check("addr waits", waits, 0);
		@(posedge hclk);
		#1;
		hwrite = 1'b0;
		hwdata = wdata;
		wait_ready(waits);
		check("write waits", waits, 0);
		@(posedge hclk);
		#1;
		htrans = krv_periph_pkg::HTRANS_IDLE;
		wait_ready(waits);
		check("read waits", waits, 0);
		check("read hresp", hresp, 1'b0);
		rdata = hrdata;
		@(posedge hclk);
		#1;
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] wd;
		logic [31:0] prev;
		logic [63:0] target;
		logic [3:0]  region;
		logic [1:0]  resp;
		int          waits;
		int          cnt;
		lfsr_state  = 32'h5b73;
		n_checks    = 0;
		n_value_err = 0;
		n_other_err = 0;
		arst_n      = 1'b0;
		haddr       = '0;
		htrans      = krv_periph_pkg::HTRANS_IDLE;
		hwrite      = 1'b0;
		hwdata      = '0;
		gpio_in     = '0;
		m_gpio_out  = '0;
		m_enable    = '0;
		m_cmp       = '1;
		repeat (16) @(posedge hclk);
		#1;
		arst_n = 1'b1;
		// Internal reset follows two edges later
		repeat (3) @(posedge hclk);
		#1;

		check("gpio_out", gpio_out, 0);
		check("core_timer_int", core_timer_int, 0);
		check("kplic_int", kplic_int, 0);
		check("hready", hready, 1);
		check("hresp", hresp, 0);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS), rd);
		check("mtimecmp_lo", rd, 32'hffff_ffff);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS), rd);
		check("mtimecmp_hi", rd, 32'hffff_ffff);

		// Random mix of write/read pairs and plain reads on the GPIO output register
		for (int i = 0; i < 16; i++) begin
			if (rand_bits(1) != 0) begin
				wd = rand_bits(32);
				write_read(reg_addr(krv_periph_pkg::REGION_GPIO, krv_periph_pkg::GPIO_OUT_OFS),
					wd, rd);
				m_gpio_out = wd[7:0];
			end else begin
				read_reg(reg_addr(krv_periph_pkg::REGION_GPIO, krv_periph_pkg::GPIO_OUT_OFS), rd);
			end
			check("hrdata gpio_out", rd, m_gpio_out);
			check("gpio_out", gpio_out, m_gpio_out);
		end
		for (int i = 0; i < 4; i++) begin
			gpio_in = 8'(rand_bits(8));
			repeat (3) @(posedge hclk);
			#1;
			read_reg(reg_addr(krv_periph_pkg::REGION_GPIO, krv_periph_pkg::GPIO_IN_OFS), rd);
			check("gpio_in reg", rd, gpio_in);
		end

		// Interrupt controller
		for (int i = 0; i < 12; i++) begin
			m_enable = 8'(rand_bits(8));
			write_reg(reg_addr(krv_periph_pkg::REGION_KPLIC, krv_periph_pkg::KPLIC_ENABLE_OFS),
				{24'h0, m_enable});
			gpio_in = 8'(rand_bits(8));
			repeat (3) @(posedge hclk);
			#1;
			read_reg(reg_addr(krv_periph_pkg::REGION_KPLIC, krv_periph_pkg::KPLIC_ENABLE_OFS), rd);
			check("enable", rd, m_enable);
			read_reg(reg_addr(krv_periph_pkg::REGION_KPLIC, krv_periph_pkg::KPLIC_PENDING_OFS), rd);
			check("pending", rd, m_enable & gpio_in);
			read_reg(reg_addr(krv_periph_pkg::REGION_KPLIC, krv_periph_pkg::KPLIC_CLAIM_OFS), rd);
			check("claim", rd, expected_claim(m_enable & gpio_in));
			check("kplic_int", kplic_int, |(m_enable & gpio_in));
		end

		// Machine timer
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIME_LO_OFS), prev);
		for (int i = 0; i < 4; i++) begin
			read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIME_LO_OFS), rd);
			n_checks++;
			assert (rd > prev) else begin
				$display("ERR %0t mtime_lo got=%h prev=%h", $time, rd, prev);
				n_value_err++;
			end
			prev = rd;
		end
		m_cmp = {rand_bits(32), rand_bits(32)};
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS),
			m_cmp[31:0]);
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS),
			m_cmp[63:32]);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS), rd);
		check("mtimecmp_lo", rd, m_cmp[31:0]);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS), rd);
		check("mtimecmp_hi", rd, m_cmp[63:32]);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIME_LO_OFS), rd);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIME_HI_OFS), wd);
		target = {wd, rd} + 64'd8 + 64'(rand_bits(6));
		m_cmp  = target;
		// Low half first, the old high half keeps the compare out of reach meanwhile
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS),
			target[31:0]);
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS),
			target[63:32]);
		check("core_timer_int", core_timer_int, 0);
		cnt = 0;
		while (!core_timer_int && cnt < TIMEOUT) begin
			@(posedge hclk);
			#1;
			cnt++;
		end
		assert (cnt < TIMEOUT) else begin
			$display("Timeout at %0t: core_timer_int never rose", $time);
			n_other_err++;
		end
		m_cmp = '1;
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS), '1);
		write_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS), '1);
		cnt = 0;
		while (core_timer_int && cnt < TIMEOUT) begin
			@(posedge hclk);
			#1;
			cnt++;
		end
		assert (cnt < TIMEOUT) else begin
			$display("Timeout at %0t: core_timer_int stayed high", $time);
			n_other_err++;
		end

		// Unmapped regions 3 to 15
		for (int i = 0; i < 4; i++) begin
			region = 4'(3 + rand_bits(4) % 13);
			transfer(1'b1, reg_addr(region, 2'(rand_bits(2))), rand_bits(32), rd, waits, resp);
			check("unmapped write waits", waits, 1);
			check("unmapped write hresp", resp, 2'b11);
			transfer(1'b0, reg_addr(region, 2'(rand_bits(2))), 32'h0, rd, waits, resp);
			check("unmapped read waits", waits, 1);
			check("unmapped read hresp", resp, 2'b11);
			check("unmapped hrdata", rd, 0);
		end
		read_reg(reg_addr(krv_periph_pkg::REGION_GPIO, krv_periph_pkg::GPIO_OUT_OFS), rd);
		check("gpio_out reg", rd, m_gpio_out);
		read_reg(reg_addr(krv_periph_pkg::REGION_KPLIC, krv_periph_pkg::KPLIC_ENABLE_OFS), rd);
		check("enable", rd, m_enable);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_LO_OFS), rd);
		check("mtimecmp_lo", rd, m_cmp[31:0]);
		read_reg(reg_addr(krv_periph_pkg::REGION_TIMER, krv_periph_pkg::MTIMECMP_HI_OFS), rd);
		check("mtimecmp_hi", rd, m_cmp[63:32]);

		$display("checks %0d, value errors %0d, other errors %0d",
			n_checks, n_value_err, n_other_err);
		if (n_value_err == 0 && n_other_err == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* krv_periph.f */
design/krv_periph_pkg.sv
design/rst_sync.sv
design/ahb_decoder.sv
design/gpio.sv
design/kplic.sv
design/core_timer.sv
design/krv_periph.sv
tb/krv_periph_tb.sv

/* Bender.yml */
package:
  name: krv_periph

sources:
  # Package first, then the leaf modules and the top level
  - files:
      - design/krv_periph_pkg.sv
      - design/rst_sync.sv
      - design/ahb_decoder.sv
      - design/gpio.sv
      - design/kplic.sv
      - design/core_timer.sv
      - design/krv_periph.sv

  - target: test
    files:
      - tb/krv_periph_tb.sv
